/* Makefile */
# Verilator build and run for the S-box engine testbench

VERILATOR ?= verilator
TOP       ?= cim_sbox_engine_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(OBJ_DIR)

/* sim.f */
src/cim_pkg.sv
src/cim_job_queue.sv
src/cim_group_ctrl.sv
src/cim_plane_stream.sv
src/cim_sbox_lookup.sv
src/cim_result_tx.sv
src/cim_sbox_engine.sv
testbench/cim_array_model.sv
testbench/cim_sbox_engine_tb.sv

/* src/cim_group_ctrl.sv */
// job sequencer; the head entry is popped only when its job finishes, so its credit returns late
`timescale 1ns/1ps

module cim_group_ctrl
    import cim_pkg::*;
(
    input  logic  CLK,
    input  logic  rst,
    input  logic  head_valid,
    input  logic  tx_ready,
    output logic  pop,
    output logic  first_group,
    output grp_t  grp,
    output beat_t beat,
    output logic  stream_en,
    output logic  sample_en,
    output logic  lookup_issue,
    output logic  lookup_capture,
    output logic  job_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_LOOKUP,
        ST_OUT
    } state_t;

    state_t state;

    // --------------------
    // read is BEATS+1 cycles, lookup is 2
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            grp   <= '0;
            beat  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (head_valid && tx_ready) begin
                        state <= ST_READ;
                        grp   <= '0;
                        beat  <= '0;
                    end
                end
                ST_READ: begin
                    if (beat == beat_t'(BEATS)) begin
                        state <= ST_LOOKUP;
                        beat  <= '0;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
                ST_LOOKUP: begin
                    if (beat == beat_t'(1)) begin
                        beat <= '0;
                        if (grp == grp_t'(NUM_GROUPS - 1)) begin
                            state <= ST_OUT;
                        end else begin
                            grp   <= grp + 1'b1;
                            state <= ST_READ;
                        end
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
                ST_OUT: begin
                    state <= ST_IDLE;
                    grp   <= '0;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // --------------------
    // phase strobes
    assign first_group    = (grp == '0);
    assign stream_en      = (state == ST_READ) && (beat < beat_t'(BEATS));
    assign sample_en      = (state == ST_READ) && (beat != '0);
    assign lookup_issue   = (state == ST_LOOKUP) && (beat == '0);
    assign lookup_capture = (state == ST_LOOKUP) && (beat == beat_t'(1));
    assign job_done       = (state == ST_OUT);

    // block and tag stay at the queue head until the result is latched
    assign pop            = job_done;

endmodule

/* src/cim_job_queue.sv */
// INQ_DEPTH-entry block queue; an overfull push is a sender error and is not checked
`timescale 1ns/1ps

module cim_job_queue
    import cim_pkg::*;
(
    input  logic   CLK,
    input  logic   rst,
    input  logic   push,
    input  block_t push_data,
    input  tag_t   push_tag,
    input  logic   pop,
    output logic   head_valid,
    output block_t head_data,
    output tag_t   head_tag,
    output logic   blk_credit
);

    block_t data_mem [INQ_DEPTH];
    tag_t   tag_mem  [INQ_DEPTH];

    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W:0]   count;
    logic              do_pop;

    function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] p);
        return (p == QPTR_W'(INQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_pop     = pop && head_valid;
    assign head_valid = (count != '0);
    assign head_data  = data_mem[rd_ptr];
    assign head_tag   = tag_mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (push) begin
            data_mem[wr_ptr] <= push_data;
            tag_mem[wr_ptr]  <= push_tag;
        end
    end

    // one credit back per freed slot
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            blk_credit <= 1'b0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            count      <= count + (QPTR_W + 1)'(push) - (QPTR_W + 1)'(do_pop);
            blk_credit <= do_pop;
        end
    end

endmodule

/* src/cim_pkg.sv */
// shared sizes and types; LANES must equal the bytes per block and INQ_DEPTH the sender's credits
package cim_pkg;

    // --------------------
    // sizes
    localparam int BLOCK_W     = 128;
    localparam int LANES       = 16;
    localparam int BYTE_W      = 8;
    localparam int WORD_W      = 16;
    localparam int BEATS       = 8;
    localparam int NUM_GROUPS  = 11;

    // flow control
    localparam int INQ_DEPTH   = 4;
    localparam int OUT_CREDITS = 2;
    localparam int TAG_W       = 8;
    localparam int QPTR_W      = $clog2(INQ_DEPTH);
    localparam int OCNT_W      = $clog2(OUT_CREDITS + 1);

    // --------------------
    // byte 0 sits in the top bits of a block
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [BYTE_W-1:0]  byte_t;

    // array address codes
    typedef logic [2:0]         demux_t;
    typedef logic [5:0]         row_t;

    // IN stream word
    typedef logic [WORD_W-1:0]  word_t;

    typedef logic [3:0]         grp_t;
    typedef logic [3:0]         beat_t;
    typedef logic [TAG_W-1:0]   tag_t;

endpackage

/* src/cim_plane_stream.sv */
// read phase datapath; rio is sampled one edge after in_bits and the lane codes settle
`timescale 1ns/1ps

module cim_plane_stream
    import cim_pkg::*;
(
    input  logic              CLK,
    input  logic              rst,
    input  block_t            head_data,
    input  block_t            lookup_result,
    input  logic              first_group,
    input  grp_t              grp,
    input  beat_t             beat,
    input  logic              stream_en,
    input  logic              sample_en,
    input  byte_t [LANES-1:0] rio,
    output word_t             in_bits,
    output demux_t            grp_demux,
    output row_t              grp_row,
    output block_t            ark
);

    block_t     src;
    grp_t       next_grp;
    beat_t      plane;
    logic [2:0] bit_sel;
    byte_t      plane_hi;
    byte_t      plane_lo;

    // 7,6,5,4 repeating, row steps every 4 groups
    function automatic demux_t group_demux(input grp_t g);
        return 3'd7 - {1'b0, g[1:0]};
    endfunction

    function automatic row_t group_row(input grp_t g);
        return row_t'(g[3:2]);
    endfunction

    assign src      = first_group ? head_data : lookup_result;
    assign next_grp = (grp == grp_t'(NUM_GROUPS - 1)) ? '0 : grp + 1'b1;

    // IN word for this beat, zero outside streaming
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            in_bits <= '0;
        end else if (stream_en) begin
            in_bits <= src[BLOCK_W - 1 - WORD_W * int'(beat) -: WORD_W];
        end else begin
            in_bits <= '0;
        end
    end

    // next group's codes set up on the last read beat, ahead of the lane registers
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            grp_demux <= group_demux('0);
            grp_row   <= group_row('0);
        end else if (sample_en && !stream_en) begin
            grp_demux <= group_demux(next_grp);
            grp_row   <= group_row(next_grp);
        end
    end

    // --------------------
    // bit plane gather
    assign plane   = beat - 1'b1;
    assign bit_sel = 3'(BEATS - int'(beat));

    always_comb begin
        for (int j = 0; j < LANES / 2; j++) begin
            plane_hi[j] = rio[j][bit_sel];
            plane_lo[j] = rio[j + LANES / 2][bit_sel];
        end
    end

    always_ff @(posedge CLK) begin
        if (sample_en) begin
            ark[BLOCK_W - 1 - WORD_W * int'(plane) -: WORD_W] <= {plane_hi, plane_lo};
        end
    end

endmodule

/* src/cim_result_tx.sv */
// one-entry result slot; res_valid is a single-cycle pulse and needs a credit in hand
`timescale 1ns/1ps

module cim_result_tx
    import cim_pkg::*;
(
    input  logic   CLK,
    input  logic   rst,
    input  logic   job_done,
    input  block_t result,
    input  tag_t   tag,
    input  logic   res_credit,
    output logic   tx_ready,
    output logic   res_valid,
    output block_t res_data,
    output tag_t   res_tag
);

    logic [OCNT_W-1:0] credit;
    logic              full;
    logic              send;

    assign send      = full && (credit != '0);
    assign res_valid = send;
    assign tx_ready  = !full && (credit != '0);

    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            full   <= 1'b0;
            credit <= OCNT_W'(OUT_CREDITS);
        end else begin
            if (job_done) begin
                full <= 1'b1;
            end else if (send) begin
                full <= 1'b0;
            end
            credit <= credit + OCNT_W'(res_credit) - OCNT_W'(send);
        end
    end

    always_ff @(posedge CLK) begin
        if (job_done) begin
            res_data <= result;
            res_tag  <= tag;
        end
    end

endmodule

/* src/cim_sbox_engine.sv */
// one block in flight at a time; the array must answer rio combinationally within a cycle
`timescale 1ns/1ps

module cim_sbox_engine
    import cim_pkg::*;
(
    input  logic               CLK,
    input  logic               rst,
    input  logic               blk_valid,
    input  block_t             blk_data,
    input  tag_t               blk_tag,
    output logic               blk_credit,
    output logic               res_valid,
    output block_t             res_data,
    output tag_t               res_tag,
    input  logic               res_credit,
    output word_t              in_bits,
    output demux_t [LANES-1:0] demux_addr,
    output row_t   [LANES-1:0] rwl_addr,
    input  byte_t  [LANES-1:0] rio
);

    logic   pop;
    logic   head_valid;
    block_t head_data;
    tag_t   head_tag;
    logic   tx_ready;
    logic   first_group;
    grp_t   grp;
    beat_t  beat;
    logic   stream_en;
    logic   sample_en;
    logic   lookup_issue;
    logic   lookup_capture;
    logic   job_done;
    demux_t grp_demux;
    row_t   grp_row;
    block_t ark;
    block_t lookup_result;

    // --------------------
    cim_job_queue cim_job_queue_inst (
        .CLK        (CLK),
        .rst        (rst),
        .push       (blk_valid),
        .push_data  (blk_data),
        .push_tag   (blk_tag),
        .pop        (pop),
        .head_valid (head_valid),
        .head_data  (head_data),
        .head_tag   (head_tag),
        .blk_credit (blk_credit)
    );

    cim_group_ctrl cim_group_ctrl_inst (
        .CLK            (CLK),
        .rst            (rst),
        .head_valid     (head_valid),
        .tx_ready       (tx_ready),
        .pop            (pop),
        .first_group    (first_group),
        .grp            (grp),
        .beat           (beat),
        .stream_en      (stream_en),
        .sample_en      (sample_en),
        .lookup_issue   (lookup_issue),
        .lookup_capture (lookup_capture),
        .job_done       (job_done)
    );

    // array side
    cim_plane_stream cim_plane_stream_inst (
        .CLK           (CLK),
        .rst           (rst),
        .head_data     (head_data),
        .lookup_result (lookup_result),
        .first_group   (first_group),
        .grp           (grp),
        .beat          (beat),
        .stream_en     (stream_en),
        .sample_en     (sample_en),
        .rio           (rio),
        .in_bits       (in_bits),
        .grp_demux     (grp_demux),
        .grp_row       (grp_row),
        .ark           (ark)
    );

    cim_sbox_lookup cim_sbox_lookup_inst (
        .CLK            (CLK),
        .rst            (rst),
        .ark            (ark),
        .grp_demux      (grp_demux),
        .grp_row        (grp_row),
        .stream_en      (stream_en),
        .lookup_issue   (lookup_issue),
        .lookup_capture (lookup_capture),
        .rio            (rio),
        .demux_addr     (demux_addr),
        .rwl_addr       (rwl_addr),
        .lookup_result  (lookup_result)
    );

    cim_result_tx cim_result_tx_inst (
        .CLK        (CLK),
        .rst        (rst),
        .job_done   (job_done),
        .result     (lookup_result),
        .tag        (head_tag),
        .res_credit (res_credit),
        .tx_ready   (tx_ready),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_tag    (res_tag)
    );

endmodule

/* src/cim_sbox_lookup.sv */
// lane address registers and lookup capture; ark must be complete before lookup_issue
`timescale 1ns/1ps

module cim_sbox_lookup
    import cim_pkg::*;
(
    input  logic               CLK,
    input  logic               rst,
    input  block_t             ark,
    input  demux_t             grp_demux,
    input  row_t               grp_row,
    input  logic               stream_en,
    input  logic               lookup_issue,
    input  logic               lookup_capture,
    input  byte_t  [LANES-1:0] rio,
    output demux_t [LANES-1:0] demux_addr,
    output row_t   [LANES-1:0] rwl_addr,
    output block_t             lookup_result
);

    // static group codes while streaming, ark-derived codes for lookup
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            demux_addr <= '0;
            rwl_addr   <= '0;
        end else if (stream_en) begin
            for (int i = 0; i < LANES; i++) begin
                demux_addr[i] <= grp_demux;
                rwl_addr[i]   <= grp_row;
            end
        end else if (lookup_issue) begin
            for (int i = 0; i < LANES; i++) begin
                // top two bits pick the column, low six the row
                demux_addr[i] <= {1'b0, ark[BLOCK_W - 1 - BYTE_W * i -: 2]};
                rwl_addr[i]   <= ark[BLOCK_W - 3 - BYTE_W * i -: 6];
            end
        end
    end

    // --------------------
    // lane i lands in byte i
    always_ff @(posedge CLK) begin
        if (lookup_capture) begin
            for (int i = 0; i < LANES; i++) begin
                lookup_result[BLOCK_W - 1 - BYTE_W * i -: BYTE_W] <= rio[i];
            end
        end
    end

endmodule

/* testbench/cim_array_model.sv */
// combinational array model; keys and table come from the testbench, only rows 0-2 carry keys
`timescale 1ns/1ps

module cim_array_model
    import cim_pkg::*;
(
    input  word_t                   in_bits,
    input  demux_t [LANES-1:0]      demux_addr,
    input  row_t   [LANES-1:0]      rwl_addr,
    input  byte_t  [NUM_GROUPS-1:0] key_hi,
    input  byte_t  [NUM_GROUPS-1:0] key_lo,
    input  byte_t  [255:0]          sbox_tbl,
    output byte_t  [LANES-1:0]      rio
);

    always_comb begin
        logic [3:0] gidx;
        byte_t      key;
        byte_t      half;
        for (int i = 0; i < LANES; i++) begin
            // demux 7..4 walks the four groups of one row
            gidx = {rwl_addr[i][1:0], ~demux_addr[i][1:0]};
            half = (i < LANES / 2) ? in_bits[15:8] : in_bits[7:0];
            if (int'(gidx) < NUM_GROUPS) begin
                key = (i < LANES / 2) ? key_hi[gidx] : key_lo[gidx];
            end else begin
                key = '0;
            end

            // static code gives a full bit plane, lookup code a table read
            if (demux_addr[i][2]) begin
                rio[i] = {8{half[i % 8] ^ key[i % 8]}};
            end else begin
                rio[i] = sbox_tbl[{demux_addr[i][1:0], rwl_addr[i]}];
            end
        end
    end

endmodule

/* testbench/cim_sbox_engine_tb.sv */
// random blocks and a slow random receiver; the array model keys and table are seeded here
`timescale 1ns/1ps

module cim_sbox_engine_tb
    import cim_pkg::*;
();

    localparam int NUM_BLOCKS = 30;
    localparam int TIMEOUT    = 60000;
    localparam int DRAIN      = 400;

    logic               CLK;
    logic               rst;
    logic               blk_valid;
    block_t             blk_data;
    tag_t               blk_tag;
    logic               blk_credit;
    logic               res_valid;
    block_t             res_data;
    tag_t               res_tag;
    logic               res_credit;
    word_t              in_bits;
    demux_t [LANES-1:0] demux_addr;
    row_t   [LANES-1:0] rwl_addr;
    byte_t  [LANES-1:0] rio;

    byte_t [NUM_GROUPS-1:0] key_hi;
    byte_t [NUM_GROUPS-1:0] key_lo;
    byte_t [255:0]          sbox_tbl;

    integer seed = 32'h870dbf7b;
    int     errors;
    int     sent;
    int     received;
    int     credits_back;
    int     tx_credits;
    int     out_avail;
    int     out_pending;
    int     static_run;
    logic   started;
    block_t exp_data [$];
    tag_t   exp_tag [$];
    word_t  exp_word [$];

    cim_sbox_engine cim_sbox_engine_inst (
        .CLK        (CLK),
        .rst        (rst),
        .blk_valid  (blk_valid),
        .blk_data   (blk_data),
        .blk_tag    (blk_tag),
        .blk_credit (blk_credit),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_tag    (res_tag),
        .res_credit (res_credit),
        .in_bits    (in_bits),
        .demux_addr (demux_addr),
        .rwl_addr   (rwl_addr),
        .rio        (rio)
    );

    cim_array_model array_model_inst (
        .in_bits    (in_bits),
        .demux_addr (demux_addr),
        .rwl_addr   (rwl_addr),
        .key_hi     (key_hi),
        .key_lo     (key_lo),
        .sbox_tbl   (sbox_tbl),
        .rio        (rio)
    );

    // --------------------
    // reference model
    function automatic block_t group_ref(input block_t src, input grp_t g);
        block_t res;
        byte_t  ark_b;
        for (int k = 0; k < LANES; k++) begin
            ark_b = src[BLOCK_W - 1 - 8 * k -: 8] ^ ((k % 2 == 0) ? key_hi[g] : key_lo[g]);
            res[BLOCK_W - 1 - 8 * k -: 8] = sbox_tbl[ark_b];
        end
        return res;
    endfunction

    // expected IN words of all groups, then the final result
    task automatic queue_job(input block_t blk, input tag_t tag);
        block_t src;
        src = blk;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            for (int c = 0; c < BEATS; c++) begin
                exp_word.push_back(src[BLOCK_W - 1 - 16 * c -: 16]);
            end
            src = group_ref(src, grp_t'(g));
        end
        exp_data.push_back(src);
        exp_tag.push_back(tag);
    endtask

    task automatic check_block(input string name, input block_t got, input block_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // --------------------
    // sender and receiver, one process so the random sequence is fixed
    always @(posedge CLK) begin : drive
        block_t blk;
        tag_t   tag;
        if (rst || !started) begin
            blk_valid  <= 1'b0;
            res_credit <= 1'b0;
        end else begin
            if (sent < NUM_BLOCKS && tx_credits > 0 && ($random(seed) & 3) != 0) begin
                blk = {$random(seed), $random(seed), $random(seed), $random(seed)};
                tag = tag_t'($random(seed));
                queue_job(blk, tag);
                blk_valid <= 1'b1;
                blk_data  <= blk;
                blk_tag   <= tag;
                tx_credits--;
                sent++;
            end else begin
                blk_valid <= 1'b0;
            end
            // credits come back slowly so the engine has to stall
            if (out_pending > 0 && ($random(seed) & 255) == 0) begin
                res_credit <= 1'b1;
                out_pending--;
            end else begin
                res_credit <= 1'b0;
            end
        end
    end

    // --------------------
    // monitor on the falling edge
    always @(negedge CLK) begin : monitor
        if (!rst) begin
            if (blk_credit) begin
                credits_back++;
                tx_credits++;
                if (tx_credits > INQ_DEPTH) begin
                    errors++;
                    $display("sender holds more than %0d input credits at %0t", INQ_DEPTH, $time);
                end
                if (credits_back > sent) begin
                    errors++;
                    $display("blk_credit returned for a block that was never sent at %0t", $time);
                end
            end

            if (res_valid) begin
                if (out_avail == 0) begin
                    errors++;
                    $display("res_valid raised with no output credit at %0t", $time);
                end
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("result arrived with no block outstanding at %0t", $time);
                end else begin
                    check_block("res_data", res_data, exp_data.pop_front());
                    check_tag("res_tag", res_tag, exp_tag.pop_front());
                end
                received++;
                out_pending++;
            end
            out_avail = out_avail + int'(res_credit) - int'(res_valid);

            // lanes carry a static code for the whole read phase
            if (demux_addr[0][2] && static_run < BEATS) begin
                if (exp_word.size() == 0) begin
                    errors++;
                    $display("in_bits streamed with no word expected at %0t", $time);
                end else begin
                    check_word("in_bits", in_bits, exp_word.pop_front());
                end
            end else begin
                check_word("in_bits", in_bits, '0);
            end
            static_run = demux_addr[0][2] ? static_run + 1 : 0;
        end
    end

    initial begin
        int wait_cnt;
        rst          = 1'b1;
        blk_valid    = 1'b0;
        blk_data     = '0;
        blk_tag      = '0;
        res_credit   = 1'b0;
        errors       = 0;
        sent         = 0;
        received     = 0;
        credits_back = 0;
        tx_credits   = INQ_DEPTH;
        out_avail    = OUT_CREDITS;
        out_pending  = 0;
        static_run   = 0;
        started      = 1'b0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            key_hi[g] = byte_t'($random(seed));
            key_lo[g] = byte_t'($random(seed));
        end
        for (int i = 0; i < 256; i++) begin
            sbox_tbl[i] = byte_t'($random(seed));
        end

        repeat (8) @(posedge CLK);
        rst <= 1'b0;

        // quiet window before the first block
        for (int c = 0; c < 16; c++) begin
            @(negedge CLK);
            check_bit("res_valid", res_valid, 1'b0);
            check_bit("blk_credit", blk_credit, 1'b0);
            check_word("in_bits", in_bits, '0);
        end
        started = 1'b1;

        wait_cnt = 0;
        while ((received < NUM_BLOCKS || credits_back < NUM_BLOCKS) && wait_cnt < TIMEOUT) begin
            @(negedge CLK);
            wait_cnt++;
        end
        if (wait_cnt >= TIMEOUT) begin
            errors++;
            $display("timed out with %0d of %0d results received", received, NUM_BLOCKS);
        end

        // extra cycles to catch a duplicated result or credit
        wait_cnt = 0;
        while (wait_cnt < DRAIN) begin
            @(negedge CLK);
            wait_cnt++;
        end
        if (received != NUM_BLOCKS || credits_back != NUM_BLOCKS || exp_word.size() != 0) begin
            errors++;
            $display("counts do not match the %0d blocks sent", NUM_BLOCKS);
        end

        $display("errors %0d, sent %0d, results %0d, input credits returned %0d",
                 errors, sent, received, credits_back);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
